// File: cpu_core.f
design/isa_pkg.sv
design/cpu_pkg.sv
design/instr_decode.sv
design/alu.sv
design/reg_file.sv
design/pc_unit.sv
design/cpu_core.sv
tb/cpu_core_tb.sv

// File: Makefile
TOP := cpu_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f cpu_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f cpu_core.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: tb/cpu_core_tb.sv
module cpu_core_tb;
  import isa_pkg::*;
  import cpu_pkg::*;

  logic   clk;
  logic   arst_n;
  instr_u instr;
  word_t  pc;
  wb_t    wb;
  logic   halted;

  // Program table, one entry per executed instruction
  string  row_name[$];
  word_t  row_pc[$];
  word_t  row_instr[$];
  wb_t    row_wb[$];
  logic   row_halted[$];
  logic   table_ready;

  int     word_errors;
  int     wb_errors;
  int     bit_errors;
  int     watchdog_limit;

  cpu_core u_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .instr  (instr),
    .pc     (pc),
    .wb     (wb),
    .halted (halted)
  );

  // Rising edges of this free-running clock commit instructions
  always #50 clk = ~clk;

  // Register form word where rt also serves as the shift amount
  function automatic word_t enc_r(opcode_e op, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
    return {op, rd, rs, rt};
  endfunction

  // Byte-load form word
  function automatic word_t enc_i(opcode_e op, reg_addr_t rd, logic [7:0] imm8);
    return {op, rd, imm8};
  endfunction

  // Branch word whose off9 is a signed offset from pc+1
  function automatic word_t enc_b(cond_e cond, logic [8:0] off9);
    return {OP_B, cond, off9};
  endfunction

  task automatic add_row(input string name, input word_t exp_pc, input word_t word,
                         input logic we, input reg_addr_t dst, input word_t data,
                         input logic exp_halted);
    wb_t entry;
    entry.we   = we;
    entry.dst  = dst;
    entry.data = data;
    row_name.push_back(name);
    row_pc.push_back(exp_pc);
    row_instr.push_back(word);
    row_wb.push_back(entry);
    row_halted.push_back(exp_halted);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      word_errors++;
      $display("ERR %s pc: expected %h actual %h", name, exp, act);
    end
  endtask

  // Destination and data only matter for a trace entry that writes
  task automatic check_wb(input string name, input wb_t exp, input wb_t act);
    if (exp.we) begin
      if (act !== exp) begin
        wb_errors++;
        $display("ERR %s wb: expected we=%b dst=%0d data=%h actual we=%b dst=%0d data=%h",
                 name, exp.we, exp.dst, exp.data, act.we, act.dst, act.data);
      end
    end else if (act.we !== 1'b0) begin
      wb_errors++;
      $display("ERR %s wb.we: expected 0 actual %b", name, act.we);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      bit_errors++;
      $display("ERR %s halted: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic build_table();
    // LLB sign-extends its constant and LHB keeps the old low byte of rd
    add_row("llb_neg",   16'd0,  enc_i(OP_LLB, 4'd1, 8'h80), 1'b1, 4'd1,  16'hFF80, 1'b0);
    add_row("lhb_merge", 16'd1,  enc_i(OP_LHB, 4'd1, 8'h12), 1'b1, 4'd1,  16'h1280, 1'b0);
    add_row("llb_pos5",  16'd2,  enc_i(OP_LLB, 4'd2, 8'h05), 1'b1, 4'd2,  16'h0005, 1'b0);
    add_row("llb_pos7f", 16'd3,  enc_i(OP_LLB, 4'd3, 8'h7F), 1'b1, 4'd3,  16'h007F, 1'b0);
    add_row("lhb_7f7f",  16'd4,  enc_i(OP_LHB, 4'd3, 8'h7F), 1'b1, 4'd3,  16'h7F7F, 1'b0);
    // The second ADD overflows into a negative result
    add_row("add",       16'd5,  enc_r(OP_ADD, 4'd4, 4'd1, 4'd2), 1'b1, 4'd4, 16'h1285, 1'b0);
    add_row("sub_neg",   16'd6,  enc_r(OP_SUB, 4'd5, 4'd2, 4'd1), 1'b1, 4'd5, 16'hED85, 1'b0);
    add_row("add_ovfl",  16'd7,  enc_r(OP_ADD, 4'd6, 4'd3, 4'd3), 1'b1, 4'd6, 16'hFEFE, 1'b0);
    add_row("b_ovfl_t",  16'd8,  enc_b(COND_OVFL, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    // AND gives zero so the first ADDZ writes and clears z, the second is skipped
    add_row("and_zero",  16'd10, enc_r(OP_AND, 4'd7, 4'd1, 4'd2), 1'b1, 4'd7, 16'h0000, 1'b0);
    add_row("addz_wr",   16'd11, enc_r(OP_ADDZ, 4'd8, 4'd2, 4'd2), 1'b1, 4'd8, 16'h000A, 1'b0);
    add_row("addz_skip", 16'd12, enc_r(OP_ADDZ, 4'd9, 4'd2, 4'd2), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("nor",       16'd13, enc_r(OP_NOR, 4'd10, 4'd1, 4'd2), 1'b1, 4'd10, 16'hED7A, 1'b0);
    // The write to r0 shows on the trace, yet r0 still reads as zero
    add_row("add_r0",    16'd14, enc_r(OP_ADD, 4'd0, 4'd2, 4'd3), 1'b1, 4'd0, 16'h7F84, 1'b0);
    add_row("read_r0",   16'd15, enc_r(OP_ADD, 4'd11, 4'd0, 4'd2), 1'b1, 4'd11, 16'h0005, 1'b0);
    add_row("sll",       16'd16, enc_r(OP_SLL, 4'd12, 4'd2, 4'd4), 1'b1, 4'd12, 16'h0050, 1'b0);
    add_row("srl",       16'd17, enc_r(OP_SRL, 4'd13, 4'd5, 4'd4), 1'b1, 4'd13, 16'h0ED8, 1'b0);
    add_row("sra_fill",  16'd18, enc_r(OP_SRA, 4'd14, 4'd5, 4'd4), 1'b1, 4'd14, 16'hFED8, 1'b0);
    add_row("srl_zero",  16'd19, enc_r(OP_SRL, 4'd15, 4'd2, 4'd3), 1'b1, 4'd15, 16'h0000, 1'b0);
    // Flags now z=1 n=0 v=0
    add_row("b_eq_t",    16'd20, enc_b(COND_EQ, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_neq_n",   16'd22, enc_b(COND_NEQ, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_gt_n",    16'd23, enc_b(COND_GT, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_lte_t",   16'd24, enc_b(COND_LTE, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_gte_t",   16'd26, enc_b(COND_GTE, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_lt_n",    16'd28, enc_b(COND_LT, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_ovfl_n",  16'd29, enc_b(COND_OVFL, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    // Forward two, back two, then forward one
    add_row("b_unc_fwd", 16'd30, enc_b(COND_UNCOND, 9'd2), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_unc_bwd", 16'd33, enc_b(COND_UNCOND, 9'h1FE), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_unc_one", 16'd32, enc_b(COND_UNCOND, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    // A negative result gives z=0 n=1
    add_row("sub_n",     16'd34, enc_r(OP_SUB, 4'd1, 4'd0, 4'd2), 1'b1, 4'd1, 16'hFFFB, 1'b0);
    add_row("b_lt_t",    16'd35, enc_b(COND_LT, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_gte_n",   16'd37, enc_b(COND_GTE, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_neq_t",   16'd38, enc_b(COND_NEQ, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_eq_n",    16'd40, enc_b(COND_EQ, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_gt_n2",   16'd41, enc_b(COND_GT, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_lte_t2",  16'd42, enc_b(COND_LTE, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    // A positive result gives z=0 n=0
    add_row("add_pos",   16'd44, enc_r(OP_ADD, 4'd1, 4'd2, 4'd2), 1'b1, 4'd1, 16'h000A, 1'b0);
    add_row("b_gt_t",    16'd45, enc_b(COND_GT, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    add_row("b_lte_n",   16'd47, enc_b(COND_LTE, 9'd1), 1'b0, 4'd0, 16'h0000, 1'b0);
    // After the halt the frozen core ignores whatever is fetched
    add_row("hlt",       16'd48, {OP_HLT, 12'h000}, 1'b0, 4'd0, 16'h0000, 1'b1);
    add_row("frozen_add", 16'd48, enc_r(OP_ADD, 4'd1, 4'd2, 4'd2), 1'b0, 4'd0, 16'h0, 1'b1);
    add_row("frozen_llb", 16'd48, enc_i(OP_LLB, 4'd2, 8'h33), 1'b0, 4'd0, 16'h0, 1'b1);
    add_row("frozen_b",  16'd48, enc_b(COND_UNCOND, 9'd4), 1'b0, 4'd0, 16'h0000, 1'b1);
  endtask

  // Ends a hung run after a budget for reset, every row and some slack
  initial begin
    wait (table_ready === 1'b1);
    watchdog_limit = (row_name.size() + 8 + 20) * 100;
    #(watchdog_limit);
    $display("Timeout: the program did not complete within %0d time units", watchdog_limit);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr       = '0;
    word_errors = 0;
    wb_errors   = 0;
    bit_errors  = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;

    repeat (8) @(negedge clk);
    arst_n = 1'b1;

    // Each pass starts on a falling edge with the previous instruction committed
    foreach (row_name[i]) begin
      check_word(row_name[i], row_pc[i], pc);
      instr = row_instr[i];
      // The trace is combinational and settles well inside the low phase
      #25;
      check_wb(row_name[i], row_wb[i], wb);
      @(negedge clk);
      check_bit(row_name[i], row_halted[i], halted);
    end
    // The last frozen row must not move the program counter either
    check_word("frozen_end", row_pc[$], pc);

    $display("Errors: pc=%0d wb=%0d halted=%0d total=%0d",
             word_errors, wb_errors, bit_errors, word_errors + wb_errors + bit_errors);
    if (word_errors + wb_errors + bit_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: design/cpu_core.sv
module cpu_core (
  input  logic            clk,
  input  logic            arst_n,
  input  isa_pkg::instr_u instr,
  output isa_pkg::word_t  pc,
  output cpu_pkg::wb_t    wb,
  output logic            halted
);
  import isa_pkg::*;
  import cpu_pkg::*;

  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  ctrl_t     ctrl;
  word_t     next_pc;
  logic      hlt;
  flags_t    flags;
  word_t     rs_data;
  word_t     rt_data;
  word_t     alu_result;

  instr_decode u_decode (
    .instr   (instr),
    .pc      (pc),
    .flags   (flags),
    .halted  (halted),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .ctrl    (ctrl),
    .next_pc (next_pc),
    .hlt     (hlt)
  );

  // Immediate comes straight from the byte-load view of the word
  alu u_alu (
    .clk    (clk),
    .arst_n (arst_n),
    .ctrl   (ctrl),
    .a      (rs_data),
    .b      (rt_data),
    .imm8   (instr.iform.imm8),
    .result (alu_result),
    .flags  (flags)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .we      (ctrl.we),
    .dst     (ctrl.dst),
    .wdata   (alu_result),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  pc_unit u_pc_unit (
    .clk     (clk),
    .arst_n  (arst_n),
    .next_pc (next_pc),
    .hlt     (hlt),
    .pc      (pc),
    .halted  (halted)
  );

  // Trace mirrors the register write port before the edge that commits it
  assign wb.we   = ctrl.we;
  assign wb.dst  = ctrl.dst;
  assign wb.data = alu_result;

endmodule

// File: design/pc_unit.sv
module pc_unit (
  input  logic           clk,
  input  logic           arst_n,
  input  isa_pkg::word_t next_pc,
  input  logic           hlt,
  output isa_pkg::word_t pc,
  output logic           halted
);
  import cpu_pkg::*;

  // The halt instruction itself does not advance the program counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else if (!halted && !hlt) begin
      pc <= next_pc;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halted <= 1'b0;
    end else if (hlt) begin
      halted <= 1'b1;
    end
  end

  // Frozen core keeps fetching the same address
  a_pc_frozen: assert property (
    @(posedge clk) disable iff (!arst_n)
    halted |=> $stable(pc)
  ) else $error("pc_unit: pc moved while halted");

endmodule

// File: design/reg_file.sv
module reg_file (
  input  logic               clk,
  input  logic               arst_n,
  input  isa_pkg::reg_addr_t rs_addr,
  input  isa_pkg::reg_addr_t rt_addr,
  input  logic               we,
  input  isa_pkg::reg_addr_t dst,
  input  isa_pkg::word_t     wdata,
  output isa_pkg::word_t     rs_data,
  output isa_pkg::word_t     rt_data
);
  import isa_pkg::*;

  word_t regs [16];

  // Writes to register 0 are accepted but never stored
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we && dst != 4'd0) begin
      regs[dst] <= wdata;
    end
  end

  // Combinational reads, register 0 forced to zero
  assign rs_data = (rs_addr == 4'd0) ? 16'h0000 : regs[rs_addr];
  assign rt_data = (rt_addr == 4'd0) ? 16'h0000 : regs[rt_addr];

  // A write needs a known destination, otherwise the decode upstream is broken
  a_dst_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    we |-> !$isunknown(dst)
  ) else $error("reg_file: write enable with unknown destination");

endmodule

// File: design/alu.sv
module alu (
  input  logic            clk,
  input  logic            arst_n,
  input  cpu_pkg::ctrl_t  ctrl,
  input  isa_pkg::word_t  a,
  input  isa_pkg::word_t  b,
  input  logic [7:0]      imm8,
  output isa_pkg::word_t  result,
  output cpu_pkg::flags_t flags
);
  import isa_pkg::*;
  import cpu_pkg::*;

  word_t op_b;
  word_t sum;
  word_t diff;
  logic  v_add;
  logic  v_sub;
  logic  v_new;
  logic  z_new;

  // Byte loads put the immediate in the high byte of the b operand
  assign op_b = ctrl.imm_sel ? {imm8, 8'h00} : b;

  assign sum  = a + op_b;
  assign diff = a - op_b;

  // Signed overflow: operands agree in sign for add, differ for subtract,
  // and the result sign does not match a
  assign v_add = (a[15] == op_b[15]) && (sum[15] != a[15]);
  assign v_sub = (a[15] != op_b[15]) && (diff[15] != a[15]);

  always_comb begin
    case (ctrl.func)
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_AND: result = a & op_b;
      ALU_NOR: result = ~(a | op_b);
      ALU_SLL: result = op_b << ctrl.shamt;
      ALU_SRL: result = op_b >> ctrl.shamt;
      // Also serves LLB, where the shift of 8 sign-extends the immediate
      ALU_SRA: result = word_t'($signed(op_b) >>> ctrl.shamt);
      // New high byte from the immediate, low byte kept from rd
      ALU_LHB: result = {op_b[15:8], a[7:0]};
      default: result = sum;
    endcase
  end

  assign z_new = (result == 16'h0000);
  assign v_new = (ctrl.func == ALU_SUB) ? v_sub : v_add;

  // Arithmetic updates all three flags, logic and shifts touch z only
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags <= '0;
    end else if (ctrl.flag_upd_all) begin
      flags.z <= z_new;
      flags.n <= result[15];
      flags.v <= v_new;
    end else if (ctrl.flag_upd_z) begin
      flags.z <= z_new;
    end
  end

  // Overflow may only move on the edge that committed an arithmetic instruction
  a_v_only_on_arith: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$past(ctrl.flag_upd_all) |-> $stable(flags.v)
  ) else $error("alu: v flag changed without an arithmetic update");

endmodule

// File: design/instr_decode.sv
module instr_decode (
  input  isa_pkg::instr_u    instr,
  input  isa_pkg::word_t     pc,
  input  cpu_pkg::flags_t    flags,
  input  logic               halted,
  output isa_pkg::reg_addr_t rs_addr,
  output isa_pkg::reg_addr_t rt_addr,
  output cpu_pkg::ctrl_t     ctrl,
  output isa_pkg::word_t     next_pc,
  output logic               hlt
);
  import isa_pkg::*;
  import cpu_pkg::*;

  opcode_e opcode;
  logic    write_ok;
  logic    cond_met;
  word_t   pc_inc;
  word_t   br_off;

  // The opcode sits in the same place in every layout
  assign opcode = instr.rform.opcode;
  assign hlt    = (opcode == OP_HLT);

  always_comb begin
    // Default register reads follow the register form
    rs_addr  = instr.rform.rs;
    rt_addr  = instr.rform.rt;
    ctrl     = '0;
    ctrl.shamt = instr.rform.rt;
    // rd is in bits 11:8 for both the register and the byte-load form
    ctrl.dst = instr.iform.rd;
    write_ok = 1'b0;
    case (opcode)
      OP_ADD: begin
        ctrl.func         = ALU_ADD;
        write_ok          = 1'b1;
        ctrl.flag_upd_all = 1'b1;
      end
      // ADDZ is a plain add that only commits while the zero flag is set
      // A skipped ADDZ leaves the flags alone as well
      OP_ADDZ: begin
        ctrl.func         = ALU_ADD;
        write_ok          = flags.z;
        ctrl.flag_upd_all = flags.z;
      end
      OP_SUB: begin
        ctrl.func         = ALU_SUB;
        write_ok          = 1'b1;
        ctrl.flag_upd_all = 1'b1;
      end
      OP_AND: begin
        ctrl.func       = ALU_AND;
        write_ok        = 1'b1;
        ctrl.flag_upd_z = 1'b1;
      end
      OP_NOR: begin
        ctrl.func       = ALU_NOR;
        write_ok        = 1'b1;
        ctrl.flag_upd_z = 1'b1;
      end
      // The shifter works on the b operand, so rs is routed through the rt read port
      OP_SLL, OP_SRL, OP_SRA: begin
        ctrl.func       = (opcode == OP_SLL) ? ALU_SLL :
                          (opcode == OP_SRL) ? ALU_SRL : ALU_SRA;
        rt_addr         = instr.rform.rs;
        write_ok        = 1'b1;
        ctrl.flag_upd_z = 1'b1;
      end
      // LHB reads rd on port a so that its low byte survives the merge
      OP_LHB: begin
        ctrl.func    = ALU_LHB;
        ctrl.imm_sel = 1'b1;
        rs_addr      = instr.iform.rd;
        write_ok     = 1'b1;
      end
      // LLB shifts {imm8, 8'h00} right by 8 arithmetically to sign-extend it
      OP_LLB: begin
        ctrl.func    = ALU_SRA;
        ctrl.imm_sel = 1'b1;
        ctrl.shamt   = 4'd8;
        write_ok     = 1'b1;
      end
      // B, JAL, JR, HLT and the unused opcodes only move the program counter
      default: begin
        write_ok = 1'b0;
      end
    endcase
    // Once halted the core is frozen and no register or flag may change
    ctrl.we = write_ok & ~halted;
    if (halted) begin
      ctrl.flag_upd_all = 1'b0;
      ctrl.flag_upd_z   = 1'b0;
    end
  end

  // Branch condition table against the registered flags
  always_comb begin
    case (instr.bform.cond)
      COND_NEQ:    cond_met = ~flags.z;
      COND_EQ:     cond_met = flags.z;
      COND_GT:     cond_met = ~flags.z & ~flags.n;
      COND_LT:     cond_met = flags.n;
      COND_GTE:    cond_met = ~flags.n;
      COND_LTE:    cond_met = flags.n | flags.z;
      COND_OVFL:   cond_met = flags.v;
      COND_UNCOND: cond_met = 1'b1;
      default:     cond_met = 1'b0;
    endcase
  end

  // Branch target is relative to the following instruction
  assign br_off  = {{7{instr.bform.off9[8]}}, instr.bform.off9};
  assign pc_inc  = pc + 16'd1;
  assign next_pc = (opcode == OP_B && cond_met) ? pc_inc + br_off : pc_inc;

  // A halt must never commit a register write in the same cycle
  always_comb begin
    assert final (!(hlt && ctrl.we))
      else $error("instr_decode: HLT decoded with write enable set");
  end

endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

  // Address of the first instruction fetched after reset
  localparam isa_pkg::word_t RESET_PC = 16'h0000;

  // ALU function select
  // LLB has no code of its own, it is the SRA path applied to {imm8, 8'h00} with a shift of 8
  typedef enum logic [2:0] {
    ALU_ADD = 3'b000,
    ALU_LHB = 3'b001,
    ALU_SUB = 3'b010,
    ALU_AND = 3'b011,
    ALU_NOR = 3'b100,
    ALU_SLL = 3'b101,
    ALU_SRL = 3'b110,
    ALU_SRA = 3'b111
  } alu_func_e;

  // Zero, negative and signed overflow flags
  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flags_t;

  // Control bundle from the decoder to the datapath
  typedef struct packed {
    alu_func_e          func;
    logic               imm_sel;
    logic [3:0]         shamt;
    isa_pkg::reg_addr_t dst;
    logic               we;
    logic               flag_upd_all;
    logic               flag_upd_z;
  } ctrl_t;

  // Write-back trace, one entry per committed instruction
  typedef struct packed {
    logic               we;
    isa_pkg::reg_addr_t dst;
    isa_pkg::word_t     data;
  } wb_t;

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

  // One machine word, used for both data and instruction addresses
  typedef logic [15:0] word_t;

  // Register number into the sixteen-entry register file
  typedef logic [3:0] reg_addr_t;

  // Major opcode in bits 15:12
  // Opcodes 1000 and 1001 (LW, SW) are not decoded and fall through as no-operations
  typedef enum logic [3:0] {
    OP_ADD  = 4'b0000,
    OP_ADDZ = 4'b0001,
    OP_SUB  = 4'b0010,
    OP_AND  = 4'b0011,
    OP_NOR  = 4'b0100,
    OP_SLL  = 4'b0101,
    OP_SRL  = 4'b0110,
    OP_SRA  = 4'b0111,
    OP_LHB  = 4'b1010,
    OP_LLB  = 4'b1011,
    OP_B    = 4'b1100,
    OP_JAL  = 4'b1101,
    OP_JR   = 4'b1110,
    OP_HLT  = 4'b1111
  } opcode_e;

  // Branch condition held in bits 11:9 of a branch
  typedef enum logic [2:0] {
    COND_NEQ    = 3'b000,
    COND_EQ     = 3'b001,
    COND_GT     = 3'b010,
    COND_LT     = 3'b011,
    COND_GTE    = 3'b100,
    COND_LTE    = 3'b101,
    COND_OVFL   = 3'b110,
    COND_UNCOND = 3'b111
  } cond_e;

  // Register form, rt also carries the shift amount for SLL, SRL and SRA
  typedef struct packed {
    opcode_e   opcode;
    reg_addr_t rd;
    reg_addr_t rs;
    reg_addr_t rt;
  } rform_t;

  // Byte-load form with an 8-bit immediate
  typedef struct packed {
    opcode_e    opcode;
    reg_addr_t  rd;
    logic [7:0] imm8;
  } iform_t;

  // Branch form with a signed 9-bit word offset
  typedef struct packed {
    opcode_e    opcode;
    cond_e      cond;
    logic [8:0] off9;
  } bform_t;

  // The same instruction word seen in each of its three layouts
  typedef union packed {
    rform_t rform;
    iform_t iform;
    bform_t bform;
  } instr_u;

endpackage
